// ==== logic/alu_macros.svh ====
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Data path and program counter width
`define ALU_DATA_W 16

// RAM word address width
`define ALU_ADDR_W 12

// Immediate field carried in v_data
`define ALU_IMM_W 8

// Flag bit positions in the flag vector and the setf/clrf mask
`define ALU_FLAG_SIGN  0
`define ALU_FLAG_ZERO  1
`define ALU_FLAG_OVF   2
`define ALU_FLAG_CARRY 3

`endif

// ==== logic/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  // Arithmetic and logic group code, as driven on op_al_code
  typedef enum logic [2:0] {
    al_and = 3'd0,
    al_or  = 3'd1,
    al_add = 3'd2,
    al_sub = 3'd3,
    al_xor = 3'd4
  } al_code_e;

  // Shift group code, which also carries inc/dec and the flag mask ops
  typedef enum logic [3:0] {
    sh_lsl  = 4'd0,
    sh_lsr  = 4'd1,
    sh_lsl8 = 4'd2,
    sh_lsr8 = 4'd3,
    sh_asr  = 4'd4,
    sh_inc  = 4'd5,
    sh_dec  = 4'd6,
    sh_setf = 4'd7,
    sh_clrf = 4'd8
  } shift_code_e;

  // Branch condition, upper four bits of op_branch_code
  typedef enum logic [3:0] {
    cond_always = 4'd0,
    cond_lt     = 4'd1,
    cond_ge     = 4'd2,
    cond_le     = 4'd3,
    cond_gt     = 4'd4,
    cond_ule    = 4'd5,
    cond_ugt    = 4'd6,
    cond_z      = 4'd7,
    cond_nz     = 4'd8,
    cond_c      = 4'd9,
    cond_nc     = 4'd10,
    cond_s      = 4'd11,
    cond_ns     = 4'd12,
    cond_v      = 4'd13,
    cond_nv     = 4'd14
  } br_cond_e;

  // One decoded operation per cycle
  typedef enum logic [4:0] {
    none,
    set_lo,
    set_hi,
    and_op,
    or_op,
    xor_op,
    add,
    sub,
    lsl,
    lsr,
    lsl8,
    lsr8,
    asr,
    inc,
    dec,
    setf,
    clrf,
    load,
    store,
    branch
  } alu_op_e;

endpackage

`default_nettype wire

// ==== logic/alu_op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_op_decode
(
  input  wire logic          op_set_val,
  input  wire logic          op_set_hi,
  input  wire logic          op_al_val,
  input  wire logic [2:0]    op_al_code,
  input  wire logic          op_shift_val,
  input  wire logic [3:0]    op_shift_code,
  input  wire logic          op_memory_val,
  input  wire logic          op_memory_st,
  input  wire logic          op_branch_val,
  input  wire logic [4:0]    op_branch_code,
  output alu_pkg::alu_op_e   op,
  output alu_pkg::br_cond_e  br_cond,
  output logic               br_relative
);

  // Condition field 15 has no meaning
  logic cond_valid;

  assign cond_valid = (op_branch_code[4:1] != 4'hf);

  // Strobe priority: set, al, shift, memory, branch
  always_comb
  begin
    op = alu_pkg::none;
    if (op_set_val)
    begin
      op = op_set_hi ? alu_pkg::set_hi : alu_pkg::set_lo;
    end
    else if (op_al_val)
    begin
      case (op_al_code)
        alu_pkg::al_and: op = alu_pkg::and_op;
        alu_pkg::al_or:  op = alu_pkg::or_op;
        alu_pkg::al_add: op = alu_pkg::add;
        alu_pkg::al_sub: op = alu_pkg::sub;
        alu_pkg::al_xor: op = alu_pkg::xor_op;
        default:         op = alu_pkg::none;
      endcase
    end
    else if (op_shift_val)
    begin
      case (op_shift_code)
        alu_pkg::sh_lsl:  op = alu_pkg::lsl;
        alu_pkg::sh_lsr:  op = alu_pkg::lsr;
        alu_pkg::sh_lsl8: op = alu_pkg::lsl8;
        alu_pkg::sh_lsr8: op = alu_pkg::lsr8;
        alu_pkg::sh_asr:  op = alu_pkg::asr;
        alu_pkg::sh_inc:  op = alu_pkg::inc;
        alu_pkg::sh_dec:  op = alu_pkg::dec;
        alu_pkg::sh_setf: op = alu_pkg::setf;
        alu_pkg::sh_clrf: op = alu_pkg::clrf;
        default:          op = alu_pkg::none;
      endcase
    end
    else if (op_memory_val)
    begin
      op = op_memory_st ? alu_pkg::store : alu_pkg::load;
    end
    else if (op_branch_val)
    begin
      op = cond_valid ? alu_pkg::branch : alu_pkg::none;
    end
  end

  // Branch code is {condition, relative}
  assign br_cond     = alu_pkg::br_cond_e'(op_branch_code[4:1]);
  assign br_relative = op_branch_code[0];

endmodule

`default_nettype wire

// ==== logic/alu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_datapath
(
  input  alu_pkg::alu_op_e            op,
  input  wire logic [`ALU_DATA_W-1:0] rf_ra,
  input  wire logic [`ALU_DATA_W-1:0] rf_rb,
  input  wire logic [`ALU_IMM_W-1:0]  v_data,
  input  wire logic [3:0]             flags,
  output logic [`ALU_DATA_W-1:0]      result,
  output logic                        carry_out,
  output logic                        overflow_out
);

  localparam int EXT_W = `ALU_DATA_W - `ALU_IMM_W;

  logic                   carry_in;
  logic [`ALU_DATA_W-1:0] imm_sext;
  logic [`ALU_DATA_W-1:0] imm_zext;

  // Shared adder operands
  logic [`ALU_DATA_W-1:0] add_b;
  logic                   add_cin;
  logic [`ALU_DATA_W:0]   sum;

  assign carry_in = flags[`ALU_FLAG_CARRY];
  assign imm_sext = {{EXT_W{v_data[`ALU_IMM_W-1]}}, v_data};
  assign imm_zext = {{EXT_W{1'b0}}, v_data};

  // Second operand and carry in per arithmetic op
  always_comb
  begin
    add_b   = '0;
    add_cin = 1'b0;
    case (op)
      alu_pkg::add:
      begin
        add_b   = rf_rb;
        add_cin = carry_in;
      end
      alu_pkg::sub:
      begin
        // Carry set means no borrow
        add_b   = ~rf_rb;
        add_cin = carry_in;
      end
      alu_pkg::inc:
      begin
        add_b   = imm_zext;
        add_cin = 1'b1;
      end
      alu_pkg::dec:
      begin
        // a + ~i is a - i - 1
        add_b   = ~imm_zext;
        add_cin = 1'b0;
      end
      default:
      begin
        add_b   = '0;
        add_cin = 1'b0;
      end
    endcase
  end

  assign sum = {1'b0, rf_ra} + {1'b0, add_b} + {{`ALU_DATA_W{1'b0}}, add_cin};

  assign carry_out = sum[`ALU_DATA_W];

  // Same-sign addends with a different-sign sum
  assign overflow_out = (rf_ra[`ALU_DATA_W-1] == add_b[`ALU_DATA_W-1]) &&
                        (sum[`ALU_DATA_W-1] != rf_ra[`ALU_DATA_W-1]);

  always_comb
  begin
    case (op)
      alu_pkg::set_lo: result = imm_sext;
      alu_pkg::set_hi: result = {v_data, rf_ra[EXT_W-1:0]};
      alu_pkg::and_op: result = rf_ra & rf_rb;
      alu_pkg::or_op:  result = rf_ra | rf_rb;
      alu_pkg::xor_op: result = rf_ra ^ rf_rb;
      alu_pkg::add,
      alu_pkg::sub,
      alu_pkg::inc,
      alu_pkg::dec:    result = sum[`ALU_DATA_W-1:0];
      // Single-bit shifts go through carry
      alu_pkg::lsl:    result = {rf_ra[`ALU_DATA_W-2:0], carry_in};
      alu_pkg::lsr:    result = {carry_in, rf_ra[`ALU_DATA_W-1:1]};
      alu_pkg::asr:    result = {rf_ra[`ALU_DATA_W-1], rf_ra[`ALU_DATA_W-1:1]};
      alu_pkg::lsl8:   result = {rf_ra[7:0], 8'h00};
      alu_pkg::lsr8:   result = {8'h00, rf_ra[`ALU_DATA_W-1:8]};
      // Store data goes out on the result bus
      alu_pkg::store:  result = rf_ra;
      default:         result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/alu_flags.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_flags
(
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  alu_pkg::alu_op_e            op,
  input  wire logic [`ALU_DATA_W-1:0] result,
  input  wire logic                   carry_out,
  input  wire logic                   overflow_out,
  input  wire logic [`ALU_IMM_W-1:0]  v_data,
  input  wire logic [`ALU_DATA_W-1:0] rf_ra,
  input  alu_pkg::br_cond_e           br_cond,
  output logic [3:0]                  flags,
  output logic                        cond_true
);

  logic [3:0] flags_nxt;
  logic [3:0] mask;
  logic       res_zero;
  logic       f_s;
  logic       f_z;
  logic       f_v;
  logic       f_c;
  logic       lt;
  logic       le;
  logic       ule;

  // Mask bits line up with the flag positions
  assign mask     = v_data[3:0];
  assign res_zero = (result == '0);

  always_comb
  begin
    flags_nxt = flags;
    case (op)
      alu_pkg::and_op,
      alu_pkg::or_op,
      alu_pkg::xor_op:
      begin
        flags_nxt[`ALU_FLAG_SIGN] = result[`ALU_DATA_W-1];
        flags_nxt[`ALU_FLAG_ZERO] = res_zero;
      end
      alu_pkg::add,
      alu_pkg::sub,
      alu_pkg::inc,
      alu_pkg::dec:
      begin
        flags_nxt[`ALU_FLAG_SIGN]  = result[`ALU_DATA_W-1];
        flags_nxt[`ALU_FLAG_ZERO]  = res_zero;
        flags_nxt[`ALU_FLAG_OVF]   = overflow_out;
        flags_nxt[`ALU_FLAG_CARRY] = carry_out;
      end
      // Carry takes the bit shifted out
      alu_pkg::lsl: flags_nxt[`ALU_FLAG_CARRY] = rf_ra[`ALU_DATA_W-1];
      alu_pkg::lsr,
      alu_pkg::asr: flags_nxt[`ALU_FLAG_CARRY] = rf_ra[0];
      alu_pkg::setf: flags_nxt = flags | mask;
      alu_pkg::clrf: flags_nxt = flags & ~mask;
      default: flags_nxt = flags;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
      flags <= '0;
    else
      flags <= flags_nxt;
  end

  assign f_s = flags[`ALU_FLAG_SIGN];
  assign f_z = flags[`ALU_FLAG_ZERO];
  assign f_v = flags[`ALU_FLAG_OVF];
  assign f_c = flags[`ALU_FLAG_CARRY];

  // Signed and unsigned compare terms
  assign lt  = f_s ^ f_v;
  assign le  = lt | f_z;
  assign ule = ~f_c | f_z;

  always_comb
  begin
    case (br_cond)
      alu_pkg::cond_always: cond_true = 1'b1;
      alu_pkg::cond_lt:     cond_true = lt;
      alu_pkg::cond_ge:     cond_true = ~lt;
      alu_pkg::cond_le:     cond_true = le;
      alu_pkg::cond_gt:     cond_true = ~le;
      alu_pkg::cond_ule:    cond_true = ule;
      alu_pkg::cond_ugt:    cond_true = ~ule;
      alu_pkg::cond_z:      cond_true = f_z;
      alu_pkg::cond_nz:     cond_true = ~f_z;
      alu_pkg::cond_c:      cond_true = f_c;
      alu_pkg::cond_nc:     cond_true = ~f_c;
      alu_pkg::cond_s:      cond_true = f_s;
      alu_pkg::cond_ns:     cond_true = ~f_s;
      alu_pkg::cond_v:      cond_true = f_v;
      alu_pkg::cond_nv:     cond_true = ~f_v;
      default:              cond_true = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/alu_branch_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_branch_mem
(
  input  alu_pkg::alu_op_e            op,
  input  wire logic [`ALU_DATA_W-1:0] pc,
  input  wire logic [`ALU_DATA_W-1:0] rf_ra,
  input  wire logic [`ALU_IMM_W-1:0]  v_data,
  input  wire logic                   br_relative,
  input  wire logic                   cond_true,
  output logic [`ALU_ADDR_W-1:0]      ram_addr,
  output logic                        ram_write,
  output logic [`ALU_DATA_W-1:0]      next_pc,
  output logic                        taken_pc
);

  localparam int ADDR_EXT_W = `ALU_ADDR_W - `ALU_IMM_W;
  localparam int DATA_EXT_W = `ALU_DATA_W - `ALU_IMM_W;

  logic                   is_mem;
  logic                   is_branch;
  logic [`ALU_ADDR_W-1:0] mem_offset;
  logic [`ALU_ADDR_W-1:0] mem_addr;
  logic [`ALU_DATA_W-1:0] br_offset;
  logic [`ALU_DATA_W-1:0] br_target;

  assign is_mem    = (op == alu_pkg::load) || (op == alu_pkg::store);
  assign is_branch = (op == alu_pkg::branch);

  // Base plus unsigned offset, wraps inside the RAM
  assign mem_offset = {{ADDR_EXT_W{1'b0}}, v_data};
  assign mem_addr   = rf_ra[`ALU_ADDR_W-1:0] + mem_offset;

  assign ram_addr  = is_mem ? mem_addr : '0;
  assign ram_write = (op == alu_pkg::store);

  // Relative form adds the signed immediate to pc
  assign br_offset = {{DATA_EXT_W{v_data[`ALU_IMM_W-1]}}, v_data};
  assign br_target = br_relative ? (pc + br_offset) : rf_ra;

  // Target is presented even when the branch is not taken
  assign next_pc  = is_branch ? br_target : '0;
  assign taken_pc = is_branch && cond_true;

endmodule

`default_nettype wire

// ==== logic/alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_top
(
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic [`ALU_DATA_W-1:0] pc,
  input  wire logic                   op_set_val,
  input  wire logic                   op_set_hi,
  input  wire logic                   op_al_val,
  input  wire logic [2:0]             op_al_code,
  input  wire logic                   op_shift_val,
  input  wire logic [3:0]             op_shift_code,
  input  wire logic                   op_memory_val,
  input  wire logic                   op_memory_st,
  input  wire logic                   op_branch_val,
  input  wire logic [4:0]             op_branch_code,
  input  wire logic [`ALU_IMM_W-1:0]  v_data,
  input  wire logic [`ALU_DATA_W-1:0] rf_ra,
  input  wire logic [`ALU_DATA_W-1:0] rf_rb,
  output logic [`ALU_DATA_W-1:0]      result,
  output logic [`ALU_ADDR_W-1:0]      ram_addr,
  output logic                        ram_write,
  output logic [`ALU_DATA_W-1:0]      next_pc,
  output logic                        taken_pc
);

  alu_pkg::alu_op_e  op;
  alu_pkg::br_cond_e br_cond;
  logic              br_relative;
  logic              carry_out;
  logic              overflow_out;
  logic [3:0]        flags;
  logic              cond_true;

  alu_op_decode u_decode
  (
    .op_set_val     (op_set_val),
    .op_set_hi      (op_set_hi),
    .op_al_val      (op_al_val),
    .op_al_code     (op_al_code),
    .op_shift_val   (op_shift_val),
    .op_shift_code  (op_shift_code),
    .op_memory_val  (op_memory_val),
    .op_memory_st   (op_memory_st),
    .op_branch_val  (op_branch_val),
    .op_branch_code (op_branch_code),
    .op             (op),
    .br_cond        (br_cond),
    .br_relative    (br_relative)
  );

  alu_datapath u_datapath
  (
    .op           (op),
    .rf_ra        (rf_ra),
    .rf_rb        (rf_rb),
    .v_data       (v_data),
    .flags        (flags),
    .result       (result),
    .carry_out    (carry_out),
    .overflow_out (overflow_out)
  );

  // Flags seen by the next instruction
  alu_flags u_flags
  (
    .clk          (clk),
    .rst          (rst),
    .op           (op),
    .result       (result),
    .carry_out    (carry_out),
    .overflow_out (overflow_out),
    .v_data       (v_data),
    .rf_ra        (rf_ra),
    .br_cond      (br_cond),
    .flags        (flags),
    .cond_true    (cond_true)
  );

  alu_branch_mem u_branch_mem
  (
    .op          (op),
    .pc          (pc),
    .rf_ra       (rf_ra),
    .v_data      (v_data),
    .br_relative (br_relative),
    .cond_true   (cond_true),
    .ram_addr    (ram_addr),
    .ram_write   (ram_write),
    .next_pc     (next_pc),
    .taken_pc    (taken_pc)
  );

endmodule

`default_nettype wire

// ==== verif/alu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_chk
(
  input wire logic                   clk,
  input wire logic                   rst,
  input wire logic                   op_set_val,
  input wire logic                   op_al_val,
  input wire logic                   op_shift_val,
  input wire logic                   op_memory_val,
  input wire logic                   op_memory_st,
  input wire logic                   op_branch_val,
  input wire logic [4:0]             op_branch_code,
  input wire logic                   ram_write,
  input wire logic [`ALU_DATA_W-1:0] next_pc,
  input wire logic                   taken_pc
);

  logic mem_selected;
  logic branch_selected;

  // Strobe priority seen from outside
  assign mem_selected    = op_memory_val && !op_set_val && !op_al_val && !op_shift_val;
  assign branch_selected = op_branch_val && !op_memory_val && !op_set_val &&
                           !op_al_val && !op_shift_val;

  // Flags are clear in the first cycle after reset
  reset_exit_z: assert property (@(posedge clk)
    ($rose(rst) && branch_selected && op_branch_code[4:1] == alu_pkg::cond_z) |-> !taken_pc)
    else $error("Branch on zero taken right after reset");

  write_on_store: assert property (@(posedge clk)
    ram_write |-> (mem_selected && op_memory_st))
    else $error("ram_write high without a store");

  taken_needs_branch: assert property (@(posedge clk)
    taken_pc |-> op_branch_val)
    else $error("taken_pc high without a branch strobe");

  idle_next_pc: assert property (@(posedge clk)
    !op_branch_val |-> (next_pc == '0))
    else $error("next_pc not zero without a branch strobe");

endmodule

bind alu_top alu_chk u_chk
(
  .clk            (clk),
  .rst            (rst),
  .op_set_val     (op_set_val),
  .op_al_val      (op_al_val),
  .op_shift_val   (op_shift_val),
  .op_memory_val  (op_memory_val),
  .op_memory_st   (op_memory_st),
  .op_branch_val  (op_branch_val),
  .op_branch_code (op_branch_code),
  .ram_write      (ram_write),
  .next_pc        (next_pc),
  .taken_pc       (taken_pc)
);

`default_nettype wire

// ==== verif/alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_tb;

  localparam int N_RANDOM    = 500;
  // Reset plus about 200 directed and the random cycles with margin
  localparam int CYCLE_LIMIT = 1000;

  logic                   clk;
  logic                   rst;
  logic [`ALU_DATA_W-1:0] pc;
  logic                   op_set_val;
  logic                   op_set_hi;
  logic                   op_al_val;
  logic [2:0]             op_al_code;
  logic                   op_shift_val;
  logic [3:0]             op_shift_code;
  logic                   op_memory_val;
  logic                   op_memory_st;
  logic                   op_branch_val;
  logic [4:0]             op_branch_code;
  logic [`ALU_IMM_W-1:0]  v_data;
  logic [`ALU_DATA_W-1:0] rf_ra;
  logic [`ALU_DATA_W-1:0] rf_rb;
  logic [`ALU_DATA_W-1:0] result;
  logic [`ALU_ADDR_W-1:0] ram_addr;
  logic                   ram_write;
  logic [`ALU_DATA_W-1:0] next_pc;
  logic                   taken_pc;

  // Reference model state and expected outputs
  logic [3:0]             mflags;
  logic [3:0]             nflags;
  logic [`ALU_DATA_W-1:0] exp_result;
  logic [`ALU_ADDR_W-1:0] exp_addr;
  logic                   exp_write;
  logic [`ALU_DATA_W-1:0] exp_next;
  logic                   exp_taken;
  logic [31:0]            rnd;

  int seed = 83654;
  int cycle_count = 0;

  alu_top dut
  (
    .clk            (clk),
    .rst            (rst),
    .pc             (pc),
    .op_set_val     (op_set_val),
    .op_set_hi      (op_set_hi),
    .op_al_val      (op_al_val),
    .op_al_code     (op_al_code),
    .op_shift_val   (op_shift_val),
    .op_shift_code  (op_shift_code),
    .op_memory_val  (op_memory_val),
    .op_memory_st   (op_memory_st),
    .op_branch_val  (op_branch_val),
    .op_branch_code (op_branch_code),
    .v_data         (v_data),
    .rf_ra          (rf_ra),
    .rf_rb          (rf_rb),
    .result         (result),
    .ram_addr       (ram_addr),
    .ram_write      (ram_write),
    .next_pc        (next_pc),
    .taken_pc       (taken_pc)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT)
      report_failure("Timeout, the run went past its cycle limit");
  end

  task automatic report_failure(input string msg);
    begin
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "Stopping after the first error");
    end
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
    begin
      report_failure($sformatf("Mismatch %s expected 0x%h got 0x%h at %0t ns",
                               name, expected, actual, $time));
    end
  endtask

  task automatic clear_inputs();
    begin
      pc             = '0;
      op_set_val     = 1'b0;
      op_set_hi      = 1'b0;
      op_al_val      = 1'b0;
      op_al_code     = '0;
      op_shift_val   = 1'b0;
      op_shift_code  = '0;
      op_memory_val  = 1'b0;
      op_memory_st   = 1'b0;
      op_branch_val  = 1'b0;
      op_branch_code = '0;
      v_data         = '0;
      rf_ra          = '0;
      rf_rb          = '0;
    end
  endtask

  // Expected outputs and next flags from the instruction now on the inputs
  task automatic predict();
    logic [16:0] sum;
    logic [15:0] b_eff;
    logic [15:0] i_sx;
    logic [15:0] i_zx;
    logic        s;
    logic        z;
    logic        v;
    logic        c;
    logic        lt;
    logic        cond;
    logic        arith;
    logic        logic_op;
    begin
      exp_result = '0;
      exp_addr   = '0;
      exp_write  = 1'b0;
      exp_next   = '0;
      exp_taken  = 1'b0;
      nflags     = mflags;
      sum        = '0;
      b_eff      = '0;
      arith      = 1'b0;
      logic_op   = 1'b0;
      i_sx       = {{8{v_data[7]}}, v_data};
      i_zx       = {8'h00, v_data};
      s          = mflags[`ALU_FLAG_SIGN];
      z          = mflags[`ALU_FLAG_ZERO];
      v          = mflags[`ALU_FLAG_OVF];
      c          = mflags[`ALU_FLAG_CARRY];
      if (op_set_val)
      begin
        exp_result = op_set_hi ? {v_data, rf_ra[7:0]} : i_sx;
      end
      else if (op_al_val)
      begin
        logic_op = 1'b1;
        case (op_al_code)
          alu_pkg::al_and: exp_result = rf_ra & rf_rb;
          alu_pkg::al_or:  exp_result = rf_ra | rf_rb;
          alu_pkg::al_xor: exp_result = rf_ra ^ rf_rb;
          alu_pkg::al_add: b_eff = rf_rb;
          alu_pkg::al_sub: b_eff = ~rf_rb;
          default:         logic_op = 1'b0;
        endcase
        if (op_al_code == alu_pkg::al_add || op_al_code == alu_pkg::al_sub)
        begin
          logic_op = 1'b0;
          arith    = 1'b1;
          sum      = {1'b0, rf_ra} + {1'b0, b_eff} + {16'h0000, c};
        end
      end
      else if (op_shift_val)
      begin
        case (op_shift_code)
          alu_pkg::sh_lsl:
          begin
            exp_result = {rf_ra[14:0], c};
            nflags[`ALU_FLAG_CARRY] = rf_ra[15];
          end
          alu_pkg::sh_lsr:
          begin
            exp_result = {c, rf_ra[15:1]};
            nflags[`ALU_FLAG_CARRY] = rf_ra[0];
          end
          alu_pkg::sh_asr:
          begin
            exp_result = {rf_ra[15], rf_ra[15:1]};
            nflags[`ALU_FLAG_CARRY] = rf_ra[0];
          end
          alu_pkg::sh_lsl8: exp_result = {rf_ra[7:0], 8'h00};
          alu_pkg::sh_lsr8: exp_result = {8'h00, rf_ra[15:8]};
          alu_pkg::sh_inc:
          begin
            arith = 1'b1;
            b_eff = i_zx;
            sum   = {1'b0, rf_ra} + {1'b0, b_eff} + 17'h00001;
          end
          alu_pkg::sh_dec:
          begin
            arith = 1'b1;
            b_eff = ~i_zx;
            sum   = {1'b0, rf_ra} + {1'b0, b_eff};
          end
          alu_pkg::sh_setf: nflags = mflags | v_data[3:0];
          alu_pkg::sh_clrf: nflags = mflags & ~v_data[3:0];
          default: ;
        endcase
      end
      else if (op_memory_val)
      begin
        exp_addr = rf_ra[11:0] + {4'h0, v_data};
        if (op_memory_st)
        begin
          exp_write  = 1'b1;
          exp_result = rf_ra;
        end
      end
      else if (op_branch_val && op_branch_code[4:1] != 4'hf)
      begin
        exp_next = op_branch_code[0] ? pc + i_sx : rf_ra;
        lt       = s ^ v;
        case (op_branch_code[4:1])
          alu_pkg::cond_always: cond = 1'b1;
          alu_pkg::cond_lt:     cond = lt;
          alu_pkg::cond_ge:     cond = !lt;
          alu_pkg::cond_le:     cond = lt | z;
          alu_pkg::cond_gt:     cond = !(lt | z);
          alu_pkg::cond_ule:    cond = !c | z;
          alu_pkg::cond_ugt:    cond = !(!c | z);
          alu_pkg::cond_z:      cond = z;
          alu_pkg::cond_nz:     cond = !z;
          alu_pkg::cond_c:      cond = c;
          alu_pkg::cond_nc:     cond = !c;
          alu_pkg::cond_s:      cond = s;
          alu_pkg::cond_ns:     cond = !s;
          alu_pkg::cond_v:      cond = v;
          default:              cond = !v;
        endcase
        exp_taken = cond;
      end
      if (arith)
      begin
        exp_result = sum[15:0];
        nflags[`ALU_FLAG_CARRY] = sum[16];
        nflags[`ALU_FLAG_OVF]   = (rf_ra[15] == b_eff[15]) && (sum[15] != rf_ra[15]);
      end
      if (arith || logic_op)
      begin
        nflags[`ALU_FLAG_SIGN] = exp_result[15];
        nflags[`ALU_FLAG_ZERO] = (exp_result == 16'h0000);
      end
    end
  endtask

  task automatic next_cycle();
    begin
      @(posedge clk);
      #1;
      clear_inputs();
    end
  endtask

  // Outputs are sampled mid-cycle and flags advance at the next edge
  task automatic settle_and_check();
    begin
      #4;
      predict();
      assert (result === exp_result)
        else report_mismatch("result", exp_result, result);
      assert (ram_addr === exp_addr)
        else report_mismatch("ram_addr", {4'h0, exp_addr}, {4'h0, ram_addr});
      assert (ram_write === exp_write)
        else report_mismatch("ram_write", {15'h0, exp_write}, {15'h0, ram_write});
      assert (next_pc === exp_next)
        else report_mismatch("next_pc", exp_next, next_pc);
      assert (taken_pc === exp_taken)
        else report_mismatch("taken_pc", {15'h0, exp_taken}, {15'h0, taken_pc});
      mflags = nflags;
    end
  endtask

  task automatic set_instr(input logic hi, input logic [7:0] imm, input logic [15:0] a);
    begin
      next_cycle();
      op_set_val = 1'b1;
      op_set_hi  = hi;
      v_data     = imm;
      rf_ra      = a;
      settle_and_check();
    end
  endtask

  task automatic al_instr(input logic [2:0] code, input logic [15:0] a, input logic [15:0] b);
    begin
      next_cycle();
      op_al_val  = 1'b1;
      op_al_code = code;
      rf_ra      = a;
      rf_rb      = b;
      settle_and_check();
    end
  endtask

  task automatic shift_instr(input logic [3:0] code, input logic [15:0] a,
                             input logic [7:0] imm);
    begin
      next_cycle();
      op_shift_val  = 1'b1;
      op_shift_code = code;
      rf_ra         = a;
      v_data        = imm;
      settle_and_check();
    end
  endtask

  task automatic mem_instr(input logic st, input logic [15:0] a, input logic [7:0] imm);
    begin
      next_cycle();
      op_memory_val = 1'b1;
      op_memory_st  = st;
      rf_ra         = a;
      v_data        = imm;
      settle_and_check();
    end
  endtask

  task automatic branch_instr(input logic [3:0] cond, input logic rel, input logic [15:0] a,
                              input logic [7:0] imm, input logic [15:0] p);
    begin
      next_cycle();
      op_branch_val  = 1'b1;
      op_branch_code = {cond, rel};
      rf_ra          = a;
      v_data         = imm;
      pc             = p;
      settle_and_check();
    end
  endtask

  // Flags seen through branches on s, z, v and c
  task automatic probe_flags();
    begin
      branch_instr(alu_pkg::cond_s, 1'b0, 16'h0100, 8'h00, 16'h0000);
      branch_instr(alu_pkg::cond_z, 1'b0, 16'h0200, 8'h00, 16'h0000);
      branch_instr(alu_pkg::cond_v, 1'b0, 16'h0300, 8'h00, 16'h0000);
      branch_instr(alu_pkg::cond_c, 1'b0, 16'h0400, 8'h00, 16'h0000);
    end
  endtask

  task automatic random_instr();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    begin
      next_cycle();
      r1             = $random(seed);
      r2             = $random(seed);
      r3             = $random(seed);
      rf_ra          = r2[15:0];
      rf_rb          = r2[31:16];
      pc             = r1[31:16];
      v_data         = r3[23:16];
      op_al_code     = r3[2:0];
      op_shift_code  = r3[6:3];
      op_branch_code = r3[11:7];
      op_set_hi      = r3[12];
      op_memory_st   = r3[13];
      case (r1[2:0])
        3'd0:       op_set_val = 1'b1;
        3'd1:       op_al_val = 1'b1;
        3'd2, 3'd3: op_shift_val = 1'b1;
        3'd4:       op_memory_val = 1'b1;
        3'd5, 3'd6: op_branch_val = 1'b1;
        default: ;
      endcase
      // Now and then a second strobe to exercise the priority
      if (r1[7:4] == 4'h0)
        op_al_val = 1'b1;
      if (r1[11:8] == 4'h0)
        op_memory_val = 1'b1;
      settle_and_check();
    end
  endtask

  initial
  begin
    rst    = 1'b0;
    mflags = '0;
    clear_inputs();
    repeat (2) next_cycle();
    // Leave reset with a branch on zero while the flags are clear
    next_cycle();
    rst            = 1'b1;
    op_branch_val  = 1'b1;
    op_branch_code = {alu_pkg::cond_z, 1'b0};
    rf_ra          = 16'h0040;
    settle_and_check();
    probe_flags();

    set_instr(1'b0, 8'h80, 16'h0000);
    set_instr(1'b0, 8'h12, 16'hffff);
    set_instr(1'b1, 8'hab, 16'h1234);
    al_instr(alu_pkg::al_and, 16'hf0f0, 16'h8ff1);
    al_instr(alu_pkg::al_or, 16'h0f00, 16'h00f0);
    probe_flags();
    al_instr(alu_pkg::al_xor, 16'h5a5a, 16'h5a5a);
    probe_flags();

    // Single-bit shifts move the old carry in
    shift_instr(alu_pkg::sh_setf, 16'h0000, 8'h08);
    shift_instr(alu_pkg::sh_lsl, 16'h8001, 8'h00);
    shift_instr(alu_pkg::sh_lsl, 16'h4000, 8'h00);
    shift_instr(alu_pkg::sh_lsr, 16'h0002, 8'h00);
    shift_instr(alu_pkg::sh_lsr, 16'h0003, 8'h00);
    shift_instr(alu_pkg::sh_lsr, 16'h0000, 8'h00);
    shift_instr(alu_pkg::sh_asr, 16'h8005, 8'h00);
    shift_instr(alu_pkg::sh_lsl8, 16'h1234, 8'h00);
    shift_instr(alu_pkg::sh_lsr8, 16'h1234, 8'h00);
    probe_flags();

    // Add and subtract chains then inc/dec with wrap
    shift_instr(alu_pkg::sh_clrf, 16'h0000, 8'h0f);
    al_instr(alu_pkg::al_add, 16'hffff, 16'h0001);
    probe_flags();
    al_instr(alu_pkg::al_add, 16'h7fff, 16'h0000);
    probe_flags();
    al_instr(alu_pkg::al_sub, 16'h0005, 16'h0003);
    probe_flags();
    al_instr(alu_pkg::al_sub, 16'h0003, 16'h0005);
    probe_flags();
    al_instr(alu_pkg::al_sub, 16'h8000, 16'h0001);
    probe_flags();
    shift_instr(alu_pkg::sh_inc, 16'hffff, 8'h00);
    probe_flags();
    shift_instr(alu_pkg::sh_inc, 16'h7fff, 8'h00);
    probe_flags();
    shift_instr(alu_pkg::sh_dec, 16'h0001, 8'h00);
    probe_flags();
    shift_instr(alu_pkg::sh_dec, 16'h0000, 8'h05);
    probe_flags();

    mem_instr(1'b0, 16'h0ffe, 8'h05);
    mem_instr(1'b1, 16'hf123, 8'hff);
    mem_instr(1'b1, 16'h0010, 8'h00);

    for (int k = 0; k < 4; k++)
    begin
      rnd = $random(seed);
      shift_instr(alu_pkg::sh_setf, 16'h0000, {4'h0, rnd[3:0]});
      shift_instr(alu_pkg::sh_clrf, 16'h0000, {4'h0, rnd[7:4]});
      probe_flags();
    end

    // Every condition in both forms, each pattern set giving both outcomes
    for (int pass = 0; pass < 3; pass++)
    begin
      shift_instr(alu_pkg::sh_clrf, 16'h0000, 8'h0f);
      shift_instr(alu_pkg::sh_setf, 16'h0000,
                  (pass == 0) ? 8'h0a : (pass == 1) ? 8'h05 : 8'h0c);
      for (int cnd = 0; cnd < 15; cnd++)
      begin
        for (int rel = 0; rel < 2; rel++)
        begin
          rnd = $random(seed);
          branch_instr(cnd[3:0], rel[0], rnd[15:0], rnd[23:16], {rnd[31:24], rnd[7:0]});
        end
      end
    end

    for (int n = 0; n < N_RANDOM; n++)
      random_instr();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== alu_core.f ====
+incdir+logic
logic/alu_pkg.sv
logic/alu_op_decode.sv
logic/alu_datapath.sv
logic/alu_flags.sv
logic/alu_branch_mem.sv
logic/alu_top.sv
verif/alu_chk.sv
verif/alu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the alu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module alu_tb \
  --Mdir "$BUILD_DIR" -o alu_sim \
  -f alu_core.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/alu_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Simulation finished without errors"
exit 0
